/* all.f */
+incdir+common
common/axi_lite_pkg.sv
common/rab_cfg_pkg.sv
hw/rab_cfg_ctrl.sv
hw/l1_cfg_regs.sv
hw/mh_fifo.sv
hw/rab_cfg_top.sv
dv/rab_cfg_checker.sv
dv/rab_cfg_tb.sv

/* dv/rab_cfg_tb.sv */
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module rab_cfg_tb;
  import axi_lite_pkg::*;
  import rab_cfg_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_REGS     = `RAB_N_REGS;
  localparam int DEPTH      = `RAB_MH_FIFO_DEPTH;
  localparam int MAX_WAIT   = 20; // cycles per handshake
  localparam int N_RANDOM   = 200;
  localparam int N_DELAYED  = 100;
  localparam int N_ROUNDS   = 4;
  // every test's transactions added up
  localparam int N_TRANS = 2*N_RANDOM + N_REGS + N_ROUNDS*3*DEPTH + 8
                           + (DEPTH+3) + 2*DEPTH + 1 + 2*N_DELAYED + 2;
  localparam logic [63:0] EMPTY_WORD = 64'd1 << `RAB_MH_EMPTY_BIT;

  logic          Clk_CI;
  logic          Rst_RBI;
  axi_lite_req_t axi_req;
  axi_lite_rsp_t axi_rsp;
  l1_cfg_array_t l1_cfg;
  logic          miss;
  miss_entry_t   miss_entry;
  logic          mh_fifo_full;

  logic [31:0]   lcg_state = 32'hf737;
  logic [63:0]   model_regs [N_REGS];
  miss_entry_t   miss_q [$];
  int            err_cnt = 0;
  int            errs_at_start = 0;
  int            asrt_seen = 0;
  int            tests_run = 0;
  int            tests_bad = 0;

  rab_cfg_top UUT (
    .Clk_CI         ( Clk_CI       ),
    .Rst_RBI        ( Rst_RBI      ),
    .axi_req_i      ( axi_req      ),
    .axi_rsp_o      ( axi_rsp      ),
    .l1_cfg_o       ( l1_cfg       ),
    .miss_i         ( miss         ),
    .miss_entry_i   ( miss_entry   ),
    .mh_fifo_full_o ( mh_fifo_full )
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever #(CLK_PERIOD/2) Clk_CI = ~Clk_CI;
  end

  initial
  begin
    #(N_TRANS * 40 * CLK_PERIOD);
    $display("watchdog expired at %0t, the run did not finish in time", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // index bits 1:0 pick the field width
  function automatic logic [63:0] model_mask(input int idx);
    logic [63:0] mask;
    case (idx % 4)
      2:       mask = (64'd1 << `RAB_ADDR_WIDTH_PHYS) - 1;
      3:       mask = (64'd1 << `RAB_N_FLAGS) - 1;
      default: mask = (64'd1 << `RAB_ADDR_WIDTH_VIRT) - 1;
    endcase
    return mask;
  endfunction

  task automatic model_write(input int idx, input logic [63:0] data, input logic [7:0] strb);
    logic [63:0] word;
    int          b;
    word = model_regs[idx];
    for (b = 0; b < 8; b++)
      if (strb[b])
        word[8*b +: 8] = data[8*b +: 8];
    model_regs[idx] = word & model_mask(idx);
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic next_cycle();
    @(posedge Clk_CI);
    #1; // drive after the edge
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input int bdelay);
    int   n;
    logic aw_hs, w_hs;
    axi_req.awaddr  = addr;
    axi_req.awvalid = 1'b1;
    axi_req.wdata   = data;
    axi_req.wstrb   = strb;
    axi_req.wvalid  = 1'b1;
    n = 0;
    while ((axi_req.awvalid || axi_req.wvalid) && n < MAX_WAIT)
    begin
      aw_hs = axi_req.awvalid && axi_rsp.awready;
      w_hs  = axi_req.wvalid && axi_rsp.wready;
      next_cycle();
      if (aw_hs)
        axi_req.awvalid = 1'b0;
      if (w_hs)
        axi_req.wvalid = 1'b0;
      n++;
    end
    if (axi_req.awvalid || axi_req.wvalid)
    begin
      $display("write to %h was never accepted by the slave", addr);
      err_cnt++;
      axi_req.awvalid = 1'b0;
      axi_req.wvalid  = 1'b0;
      return;
    end
    n = 0;
    while (!axi_rsp.bvalid && n < MAX_WAIT)
    begin
      next_cycle();
      n++;
    end
    if (!axi_rsp.bvalid)
    begin
      $display("write to %h got no write response", addr);
      err_cnt++;
      return;
    end
    expect_eq("bresp", 64'(axi_rsp.bresp), 64'd0); // always OKAY
    repeat (bdelay) next_cycle();
    axi_req.bready = 1'b1;
    next_cycle();
    axi_req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input int rdelay, output logic [63:0] data);
    int n;
    data = 'x;
    axi_req.araddr  = addr;
    axi_req.arvalid = 1'b1;
    n = 0;
    while (!axi_rsp.arready && n < MAX_WAIT)
    begin
      next_cycle();
      n++;
    end
    if (!axi_rsp.arready)
    begin
      $display("read of %h was never accepted by the slave", addr);
      err_cnt++;
      axi_req.arvalid = 1'b0;
      return;
    end
    next_cycle();
    axi_req.arvalid = 1'b0;
    n = 0;
    while (!axi_rsp.rvalid && n < MAX_WAIT)
    begin
      next_cycle();
      n++;
    end
    if (!axi_rsp.rvalid)
    begin
      $display("read of %h got no read data", addr);
      err_cnt++;
      return;
    end
    repeat (rdelay) next_cycle();
    data = axi_rsp.rdata;
    expect_eq("rresp", 64'(axi_rsp.rresp), 64'd0); // always OKAY
    axi_req.rready = 1'b1;
    next_cycle();
    axi_req.rready = 1'b0;
  endtask

  task automatic write_read_check(input int idx, input int bdelay, input int rdelay);
    logic [63:0] data;
    logic [63:0] rd;
    logic [31:0] r;
    data[63:32] = rand32();
    data[31:0]  = rand32();
    r = rand32();
    axi_write(32'(idx << 3), data, r[31:24], bdelay);
    model_write(idx, data, r[31:24]);
    axi_read(32'(idx << 3), rdelay, rd);
    expect_eq($sformatf("rdata of reg %0d", idx), rd, model_regs[idx]);
    expect_eq($sformatf("l1_cfg_o[%0d]", idx), l1_cfg[idx], model_regs[idx]);
  endtask

  task automatic check_all_regs();
    int i;
    for (i = 0; i < N_REGS; i++)
      expect_eq($sformatf("l1_cfg_o[%0d]", i), l1_cfg[i], model_regs[i]);
  endtask

  // one pulse, full flag expected only with the model queue full
  task automatic push_miss();
    logic [31:0] r;
    logic        exp_full;
    r = rand32();
    miss_entry.addr = rand32();
    miss_entry.meta = r[`RAB_MISS_META_WIDTH-1:0];
    miss = 1'b1;
    exp_full = miss_q.size() >= DEPTH;
    #2;
    expect_eq("mh_fifo_full_o", 64'(mh_fifo_full), 64'(exp_full));
    if (!exp_full)
      miss_q.push_back(miss_entry);
    @(posedge Clk_CI);
    #1;
    miss = 1'b0;
  endtask

  task automatic drain_one();
    miss_entry_t e;
    logic [63:0] rd;
    e = miss_q.pop_front();
    axi_read(`RAB_MH_ADDR_OFFS, 0, rd);
    expect_eq("rdata of miss address", rd, 64'(e.addr));
    axi_read(`RAB_MH_META_OFFS, 0, rd);
    expect_eq("rdata of miss metadata", rd, 64'(e.meta)); // empty bit clear
  endtask

  task automatic check_empty();
    logic [63:0] rd;
    axi_read(`RAB_MH_META_OFFS, 0, rd);
    expect_eq("rdata of metadata when empty", rd, EMPTY_WORD);
  endtask

  task automatic begin_test();
    errs_at_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    int n_asrt;
    n_asrt = UUT.i_ctrl.i_checker.fail_cnt - asrt_seen;
    if (n_asrt != 0)
    begin
      $display("%0d handshake assertions failed during test %0d", n_asrt, tests_run + 1);
      err_cnt   += n_asrt;
      asrt_seen += n_asrt;
    end
    tests_run++;
    if (err_cnt == errs_at_start)
      $display("test %0d (%s): ok", tests_run, name);
    else
    begin
      tests_bad++;
      $display("test %0d (%s): %0d errors", tests_run, name, err_cnt - errs_at_start);
    end
  endtask

  initial
  begin
    int          i, k, n;
    logic [31:0] r;
    logic [63:0] rd;
    axi_req    = '0;
    miss       = 1'b0;
    miss_entry = '0;
    Rst_RBI    = 1'b0;
    for (i = 0; i < N_REGS; i++)
      model_regs[i] = '0;
    repeat (3) @(posedge Clk_CI);
    #1;
    Rst_RBI = 1'b1;

    begin_test();
    expect_eq("awready", 64'(axi_rsp.awready), 64'd1);
    expect_eq("wready", 64'(axi_rsp.wready), 64'd1);
    expect_eq("arready", 64'(axi_rsp.arready), 64'd1);
    expect_eq("bvalid", 64'(axi_rsp.bvalid), 64'd0);
    expect_eq("rvalid", 64'(axi_rsp.rvalid), 64'd0);
    expect_eq("mh_fifo_full_o", 64'(mh_fifo_full), 64'd0);
    check_all_regs();
    end_test("reset values");

    begin_test();
    for (k = 0; k < N_RANDOM; k++)
    begin
      r = rand32();
      write_read_check(int'(r[31:27]), 0, 0);
    end
    end_test("random strobed writes");

    begin_test();
    for (i = 0; i < N_REGS; i++)
    begin
      axi_read(32'((i << 3) | 4), 0, rd);
      expect_eq($sformatf("upper rdata of reg %0d", i), rd, {32'd0, model_regs[i][63:32]});
    end
    end_test("upper word reads");

    begin_test();
    for (k = 0; k < N_ROUNDS; k++)
    begin
      r = rand32();
      n = 1 + int'(r[31:16] % DEPTH);
      for (i = 0; i < n; i++)
      begin
        push_miss();
        r = rand32();
        repeat (int'(r[31:16] % 3)) next_cycle(); // idle gap
      end
      for (i = 0; i < n; i++)
        drain_one();
      check_empty();
    end
    push_miss(); // empty read above must not have popped
    drain_one();
    check_empty();
    end_test("miss queue order");

    begin_test();
    for (k = 0; k < DEPTH + 3; k++)
      push_miss();
    for (k = 0; k < DEPTH; k++)
      drain_one();
    check_empty();
    end_test("miss queue overflow");

    begin_test();
    for (k = 0; k < N_DELAYED; k++)
    begin
      r = rand32();
      write_read_check(int'(r[31:27]), int'(r[15:8] % 6), int'(r[7:0] % 6));
    end
    axi_write(`RAB_MH_ADDR_OFFS, {rand32(), 32'hffff_ffff}, 8'hff, 2);
    axi_write(`RAB_MH_META_OFFS, {32'hffff_ffff, rand32()}, 8'hff, 0);
    check_all_regs();
    end_test("back-pressure and window writes");

    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             tests_run, tests_bad, err_cnt);
    if (err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* dv/rab_cfg_checker.sv */
`timescale 1ns/1ps

module rab_cfg_checker (
  input logic                        Clk_CI,
  input logic                        Rst_RBI,
  input axi_lite_pkg::axi_lite_req_t axi_req_i,
  input axi_lite_pkg::axi_lite_rsp_t axi_rsp_o,
  input rab_cfg_pkg::cfg_wr_t        reg_wr_o
);

  int fail_cnt = 0; // failed assertions so far

  bvalid_held: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_rsp_o.bvalid && !axi_req_i.bready |=> axi_rsp_o.bvalid)
    else
    begin
      $error("bvalid dropped before the B handshake");
      fail_cnt++;
    end

  rvalid_held: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_rsp_o.rvalid && !axi_req_i.rready |=> axi_rsp_o.rvalid)
    else
    begin
      $error("rvalid dropped before the R handshake");
      fail_cnt++;
    end

  // payload must not move under back-pressure
  rdata_stable: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_rsp_o.rvalid && !axi_req_i.rready |=> $stable(axi_rsp_o.rdata))
    else
    begin
      $error("rdata changed while rvalid was waiting");
      fail_cnt++;
    end

  wr_en_pulse: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    reg_wr_o.en |=> !reg_wr_o.en)
    else
    begin
      $error("register write enable longer than one cycle");
      fail_cnt++;
    end

  no_aw_during_b: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_rsp_o.bvalid |-> !axi_rsp_o.awready)
    else
    begin
      $error("awready high while bvalid pending");
      fail_cnt++;
    end

endmodule

bind rab_cfg_ctrl rab_cfg_checker i_checker (
  .Clk_CI    ( Clk_CI    ),
  .Rst_RBI   ( Rst_RBI   ),
  .axi_req_i ( axi_req_i ),
  .axi_rsp_o ( axi_rsp_o ),
  .reg_wr_o  ( reg_wr_o  )
);

/* hw/rab_cfg_top.sv */
`timescale 1ns/1ps

module rab_cfg_top (
  input  logic                        Clk_CI,
  input  logic                        Rst_RBI,
  input  axi_lite_pkg::axi_lite_req_t axi_req_i,
  output axi_lite_pkg::axi_lite_rsp_t axi_rsp_o,
  output rab_cfg_pkg::l1_cfg_array_t  l1_cfg_o,
  input  logic                        miss_i,
  input  rab_cfg_pkg::miss_entry_t    miss_entry_i,
  output logic                        mh_fifo_full_o
);
  import rab_cfg_pkg::*;

  cfg_wr_t     reg_wr;
  reg_idx_t    rd_idx;
  logic [63:0] rd_data;
  miss_entry_t mh_head;
  logic        mh_empty;
  logic        mh_pop;

  // axi-lite slave side
  rab_cfg_ctrl i_ctrl (
    .Clk_CI     ( Clk_CI    ),
    .Rst_RBI    ( Rst_RBI   ),
    .axi_req_i  ( axi_req_i ),
    .axi_rsp_o  ( axi_rsp_o ),
    .reg_wr_o   ( reg_wr    ),
    .rd_idx_o   ( rd_idx    ),
    .rd_data_i  ( rd_data   ),
    .mh_head_i  ( mh_head   ),
    .mh_empty_i ( mh_empty  ),
    .mh_pop_o   ( mh_pop    )
  );

  l1_cfg_regs i_regs (
    .Clk_CI    ( Clk_CI   ),
    .Rst_RBI   ( Rst_RBI  ),
    .reg_wr_i  ( reg_wr   ),
    .rd_idx_i  ( rd_idx   ),
    .rd_data_o ( rd_data  ),
    .l1_cfg_o  ( l1_cfg_o )
  );

  // full flag is the drop pulse
  mh_fifo i_mh_fifo (
    .Clk_CI     ( Clk_CI         ),
    .Rst_RBI    ( Rst_RBI        ),
    .push_i     ( miss_i         ),
    .entry_i    ( miss_entry_i   ),
    .pop_i      ( mh_pop         ),
    .head_o     ( mh_head        ),
    .empty_o    ( mh_empty       ),
    .overflow_o ( mh_fifo_full_o )
  );

endmodule

/* hw/mh_fifo.sv */
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module mh_fifo (
  input  logic                     Clk_CI,
  input  logic                     Rst_RBI,
  input  logic                     push_i,
  input  rab_cfg_pkg::miss_entry_t entry_i,
  input  logic                     pop_i,
  output rab_cfg_pkg::miss_entry_t head_o,
  output logic                     empty_o,
  output logic                     overflow_o
);
  import rab_cfg_pkg::*;

  localparam int DEPTH = `RAB_MH_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  miss_entry_t      mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             full, do_push, do_pop;

  assign full       = count_q == (PTR_W+1)'(DEPTH);
  assign empty_o    = count_q == '0;
  assign do_push    = push_i & ~full;
  assign do_pop     = pop_i & ~empty_o; // pop on empty ignored
  assign overflow_o = push_i & full;    // entry dropped this cycle
  assign head_o     = mem_q[rd_ptr_q];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or none
      endcase
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= entry_i;
  end

endmodule

/* hw/l1_cfg_regs.sv */
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module l1_cfg_regs (
  input  logic                           Clk_CI,
  input  logic                           Rst_RBI,
  input  rab_cfg_pkg::cfg_wr_t           reg_wr_i,
  input  rab_cfg_pkg::reg_idx_t          rd_idx_i,
  output logic [`RAB_AXI_DATA_WIDTH-1:0] rd_data_o,
  output rab_cfg_pkg::l1_cfg_array_t     l1_cfg_o
);
  import rab_cfg_pkg::*;

  localparam int DW = `RAB_AXI_DATA_WIDTH;

  // kind from index bits 1:0
  function automatic l1_field_e field_of(input reg_idx_t idx);
    l1_field_e kind;
    if (!idx[1])
      kind = FIELD_VIRT;
    else if (!idx[0])
      kind = FIELD_PHYS;
    else
      kind = FIELD_FLAGS;
    return kind;
  endfunction

  function automatic logic [DW-1:0] field_mask(input l1_field_e kind);
    logic [DW-1:0] mask;
    case (kind)
      FIELD_VIRT:
        mask = {{(DW - `RAB_ADDR_WIDTH_VIRT){1'b0}}, {`RAB_ADDR_WIDTH_VIRT{1'b1}}};
      FIELD_PHYS:
        mask = {{(DW - `RAB_ADDR_WIDTH_PHYS){1'b0}}, {`RAB_ADDR_WIDTH_PHYS{1'b1}}};
      default:
        mask = {{(DW - `RAB_N_FLAGS){1'b0}}, {`RAB_N_FLAGS{1'b1}}};
    endcase
    return mask;
  endfunction

  l1_cfg_array_t regs_q;
  logic [DW-1:0] wr_word;
  logic [DW-1:0] wr_mask;

  // byte merge of old contents and strobed data
  always_comb
  begin
    wr_word = regs_q[reg_wr_i.idx];
    for (int b = 0; b < DW/8; b++)
      if (reg_wr_i.strb[b])
        wr_word[8*b +: 8] = reg_wr_i.data[8*b +: 8];
  end

  assign wr_mask = field_mask(field_of(reg_wr_i.idx));

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      regs_q <= '0;
    else if (reg_wr_i.en)
      regs_q[reg_wr_i.idx] <= wr_word & wr_mask; // bits outside the field cleared
  end

  for (genvar j = 0; j < `RAB_N_REGS; j++)
  begin : g_out_mask
    assign l1_cfg_o[j] = regs_q[j] & field_mask(field_of(reg_idx_t'(j)));
  end

  assign rd_data_o = l1_cfg_o[rd_idx_i];

endmodule

/* hw/rab_cfg_ctrl.sv */
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module rab_cfg_ctrl (
  input  logic                            Clk_CI,
  input  logic                            Rst_RBI,
  input  axi_lite_pkg::axi_lite_req_t     axi_req_i,
  output axi_lite_pkg::axi_lite_rsp_t     axi_rsp_o,
  output rab_cfg_pkg::cfg_wr_t            reg_wr_o,
  output rab_cfg_pkg::reg_idx_t           rd_idx_o,
  input  logic [`RAB_AXI_DATA_WIDTH-1:0]  rd_data_i,
  input  rab_cfg_pkg::miss_entry_t        mh_head_i,
  input  logic                            mh_empty_i,
  output logic                            mh_pop_o
);
  import axi_lite_pkg::*;
  import rab_cfg_pkg::*;

  localparam int AW       = `RAB_AXI_ADDR_WIDTH;
  localparam int DW       = `RAB_AXI_DATA_WIDTH;
  localparam int ADDR_LSB = 3; // registers are 64 bit wide
  localparam int IDX_W    = $bits(reg_idx_t);
  localparam logic [AW-1:0] MH_ADDR_OFFS = `RAB_MH_ADDR_OFFS;
  localparam logic [AW-1:0] MH_META_OFFS = `RAB_MH_META_OFFS;

  wr_state_e         wr_state;
  rd_state_e         rd_state;
  logic              awready_q, wready_q, bvalid_q, b_done_q;
  logic              arready_q, rvalid_q, r_done_q;
  logic              reg_wr_en_q;
  logic              rd_pop_q;
  logic [AW-1:0]     awaddr_q, araddr_q, ar_word;
  logic [DW-1:0]     wdata_q, rdata_q, rd_word;
  logic [DW/8-1:0]   wstrb_q;
  logic              aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic              wr_fire, rd_load, wr_in_bank, ar_is_addr, ar_is_meta;

  assign aw_hs = axi_req_i.awvalid & awready_q;
  assign w_hs  = axi_req_i.wvalid & wready_q;
  assign b_hs  = bvalid_q & axi_req_i.bready;
  assign ar_hs = axi_req_i.arvalid & arready_q;
  assign r_hs  = rvalid_q & axi_req_i.rready;

  // first cycle in the response state, before valid goes up
  assign wr_fire = (wr_state == WR_RESP) && !bvalid_q && !b_done_q;
  assign rd_load = (rd_state == RD_RESP) && !rvalid_q && !r_done_q;

  assign wr_in_bank = awaddr_q < MH_ADDR_OFFS; // fifo window swallows writes
  assign ar_word    = {araddr_q[AW-1:ADDR_LSB], {ADDR_LSB{1'b0}}};
  assign ar_is_addr = ar_word == MH_ADDR_OFFS;
  assign ar_is_meta = ar_word == MH_META_OFFS;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_state    <= WR_IDLE;
      awready_q   <= 1'b1;
      wready_q    <= 1'b1;
      bvalid_q    <= 1'b0;
      b_done_q    <= 1'b0;
      reg_wr_en_q <= 1'b0;
    end
    else
    begin
      reg_wr_en_q <= 1'b0;
      if (aw_hs)
        awready_q <= 1'b0;
      if (w_hs)
        wready_q <= 1'b0;
      case (wr_state)
        WR_IDLE:
        begin
          if (aw_hs && w_hs)
            wr_state <= WR_RESP;
          else if (aw_hs)
            wr_state <= WR_HAVE_ADDR;
          else if (w_hs)
            wr_state <= WR_HAVE_DATA;
        end
        WR_HAVE_ADDR:
          if (w_hs)
            wr_state <= WR_RESP;
        WR_HAVE_DATA:
          if (aw_hs)
            wr_state <= WR_RESP;
        default:
        begin
          if (wr_fire)
          begin
            bvalid_q    <= 1'b1;
            reg_wr_en_q <= wr_in_bank; // single pulse
          end
          if (b_hs)
          begin
            bvalid_q <= 1'b0;
            b_done_q <= 1'b1;
          end
          if (b_done_q)
          begin
            b_done_q  <= 1'b0;
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
            wr_state  <= WR_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      rd_state  <= RD_IDLE;
      arready_q <= 1'b1;
      rvalid_q  <= 1'b0;
      r_done_q  <= 1'b0;
      rd_pop_q  <= 1'b0;
    end
    else if (rd_state == RD_IDLE)
    begin
      if (ar_hs)
      begin
        arready_q <= 1'b0;
        rd_state  <= RD_RESP;
      end
    end
    else
    begin
      if (rd_load)
      begin
        rvalid_q <= 1'b1;
        rd_pop_q <= ar_is_meta && !mh_empty_i; // pop only what was returned
      end
      if (r_hs)
      begin
        rvalid_q <= 1'b0;
        r_done_q <= 1'b1;
      end
      if (r_done_q)
      begin
        r_done_q  <= 1'b0;
        arready_q <= 1'b1;
        rd_state  <= RD_IDLE;
      end
    end
  end

  // captured payload
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      awaddr_q <= axi_req_i.awaddr;
    if (w_hs)
    begin
      wdata_q <= axi_req_i.wdata;
      wstrb_q <= axi_req_i.wstrb;
    end
    if (ar_hs)
      araddr_q <= axi_req_i.araddr;
    if (rd_load)
      rdata_q <= rd_word; // held stable while rvalid waits
  end

  always_comb
  begin
    rd_word = '0;
    if (ar_is_addr)
    begin
      if (!mh_empty_i)
        rd_word[`RAB_ADDR_WIDTH_VIRT-1:0] = mh_head_i.addr;
    end
    else if (ar_is_meta)
    begin
      if (!mh_empty_i)
        rd_word[`RAB_MISS_META_WIDTH-1:0] = mh_head_i.meta;
      rd_word[`RAB_MH_EMPTY_BIT] = mh_empty_i;
    end
    else if (araddr_q[2])
      rd_word = {{(DW/2){1'b0}}, rd_data_i[DW-1:DW/2]}; // upper word for 32-bit masters
    else
      rd_word = rd_data_i;
  end

  assign reg_wr_o.en   = reg_wr_en_q;
  assign reg_wr_o.idx  = awaddr_q[ADDR_LSB +: IDX_W];
  assign reg_wr_o.data = wdata_q;
  assign reg_wr_o.strb = wstrb_q;
  assign rd_idx_o      = araddr_q[ADDR_LSB +: IDX_W];
  assign mh_pop_o      = r_hs & rd_pop_q;

  assign axi_rsp_o.awready = awready_q;
  assign axi_rsp_o.wready  = wready_q;
  assign axi_rsp_o.bvalid  = bvalid_q;
  assign axi_rsp_o.bresp   = RESP_OKAY;
  assign axi_rsp_o.arready = arready_q;
  assign axi_rsp_o.rvalid  = rvalid_q;
  assign axi_rsp_o.rdata   = rdata_q;
  assign axi_rsp_o.rresp   = RESP_OKAY;

endmodule

/* common/rab_cfg_pkg.sv */
`include "rab_cfg_cfg.svh"

package rab_cfg_pkg;

  localparam int REG_IDX_WIDTH = $clog2(`RAB_N_REGS);

  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

  // write channel FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_HAVE_ADDR,
    WR_HAVE_DATA,
    WR_RESP
  } wr_state_e;

  // read channel FSM
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  // encoding follows index bits 1:0
  typedef enum logic [1:0] {
    FIELD_VIRT  = 2'b00,
    FIELD_PHYS  = 2'b10,
    FIELD_FLAGS = 2'b11
  } l1_field_e;

  typedef struct packed {
    logic                             en;
    reg_idx_t                         idx;
    logic [`RAB_AXI_DATA_WIDTH-1:0]   data;
    logic [`RAB_AXI_DATA_WIDTH/8-1:0] strb;
  } cfg_wr_t;

  typedef struct packed {
    logic [`RAB_ADDR_WIDTH_VIRT-1:0] addr;
    logic [`RAB_MISS_META_WIDTH-1:0] meta;
  } miss_entry_t;

  typedef logic [`RAB_N_REGS-1:0][`RAB_AXI_DATA_WIDTH-1:0] l1_cfg_array_t;

endpackage

/* common/axi_lite_pkg.sv */
`include "rab_cfg_cfg.svh"

package axi_lite_pkg;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // driven by the master
  typedef struct packed {
    logic [`RAB_AXI_ADDR_WIDTH-1:0]   awaddr;
    logic                             awvalid;
    logic [`RAB_AXI_DATA_WIDTH-1:0]   wdata;
    logic [`RAB_AXI_DATA_WIDTH/8-1:0] wstrb;
    logic                             wvalid;
    logic                             bready;
    logic [`RAB_AXI_ADDR_WIDTH-1:0]   araddr;
    logic                             arvalid;
    logic                             rready;
  } axi_lite_req_t;

  // driven by the slave
  typedef struct packed {
    logic                           awready;
    logic                           wready;
    logic                           bvalid;
    axi_resp_t                      bresp;
    logic                           arready;
    logic                           rvalid;
    logic [`RAB_AXI_DATA_WIDTH-1:0] rdata;
    axi_resp_t                      rresp;
  } axi_lite_rsp_t;

endpackage

/* common/rab_cfg_cfg.svh */
`ifndef RAB_CFG_CFG_SVH
`define RAB_CFG_CFG_SVH

// bus geometry
`define RAB_AXI_ADDR_WIDTH 32
`define RAB_AXI_DATA_WIDTH 64

// l1 slice register bank, power of two
`define RAB_N_REGS 32

// valid bits per field kind
`define RAB_ADDR_WIDTH_VIRT 32
`define RAB_ADDR_WIDTH_PHYS 40
`define RAB_N_FLAGS 4

// miss handling
`define RAB_MISS_META_WIDTH 10
`define RAB_MH_FIFO_DEPTH 8
`define RAB_MH_ADDR_OFFS 32'h0000_4000
`define RAB_MH_META_OFFS 32'h0000_4008
`define RAB_MH_EMPTY_BIT 31 // empty flag in the metadata word

`endif
